/* bench/mem_controller_properties.sv */
// cpu port handshake properties for the memory controller, bound into the top level
module mem_controller_properties (
   input logic clk,
   input logic rst,
   input logic dat_cyc_i,
   input logic dat_stb_i,
   input logic dat_ack_o,
   input logic ins_cyc_i,
   input logic ins_stb_i,
   input logic ins_ack_o
);
   timeunit 1ns;
   timeprecision 100ps;

   // single cycle acks
   dat_ack_pulse: assert property (@(posedge clk) disable iff (rst) dat_ack_o |=> !dat_ack_o)
      else $error("data port ack held longer than one cycle");
   ins_ack_pulse: assert property (@(posedge clk) disable iff (rst) ins_ack_o |=> !ins_ack_o)
      else $error("fetch port ack held longer than one cycle");

   // ack only answers an open request
   dat_ack_req: assert property (@(posedge clk) disable iff (rst)
                                 dat_ack_o |-> (dat_cyc_i && dat_stb_i))
      else $error("data port ack without cyc and stb");
   ins_ack_req: assert property (@(posedge clk) disable iff (rst)
                                 ins_ack_o |-> (ins_cyc_i && ins_stb_i))
      else $error("fetch port ack without cyc and stb");

   // quiet under reset
   ack_in_reset: assert property (@(posedge clk) rst |-> (!dat_ack_o && !ins_ack_o))
      else $error("port ack high during reset");

endmodule

bind mem_controller mem_controller_properties i_props (
   .clk(clk), .rst(rst),
   .dat_cyc_i(dat_cyc_i), .dat_stb_i(dat_stb_i), .dat_ack_o(dat_ack_o),
   .ins_cyc_i(ins_cyc_i), .ins_stb_i(ins_stb_i), .ins_ack_o(ins_ack_o)
);

/* bench/mem_trace.txt */
# port(D data, I fetch) op(R read, W write) address sel write_data expected_read pair
# all numbers hex except pair; pair 1 issues this entry and the next one together
D R 00000000 f 00000000 00000000 0
I R 00000100 f 00000000 00000000 0
D R 000003fc f 00000000 00000000 0
I R 80000200 f 00000000 00000000 0
D W 00000010 f 11223344 00000000 0
D R 00000010 f 00000000 11223344 0
D W 00000010 2 0000aa00 00000000 0
D R 00000010 f 00000000 1122aa44 0
D W 00000010 9 ee0000ff 00000000 0
D R 00000010 f 00000000 ee22aaff 0
I R 00000010 f 00000000 ee22aaff 0
D W 00000020 c 55660000 00000000 0
D R 00000020 f 00000000 55660000 0
D W 1f800010 f cafef00d 00000000 0
D R 1f800010 f 00000000 cafef00d 0
D R 00000010 f 00000000 ee22aaff 0
I R 1f800010 f 00000000 cafef00d 0
D W 1f800010 1 000000aa 00000000 0
D R 1f800010 f 00000000 cafef0aa 0
D W 1f8003fc f 0badbeef 00000000 0
D R 1f8003fc f 00000000 0badbeef 0
D R 000003fc f 00000000 00000000 0
D R 00000410 f 00000000 ee22aaff 0
D R 12340010 f 00000000 ee22aaff 0
D W 00a00420 f 01020304 00000000 0
D R 00000020 f 00000000 01020304 0
I R 7ffffc20 f 00000000 01020304 0
D R 1f800400 f 00000000 00000000 0
D R 1f7ffffc f 00000000 00000000 0
D W 00000030 f a5a5a5a5 00000000 0
D R 00000030 f 00000000 a5a5a5a5 1
I R 00000020 f 00000000 01020304 0
I R 1f800010 f 00000000 cafef0aa 1
D W 00000040 f 12345678 00000000 0
D W 1f800020 f 77778888 00000000 1
I R 00000040 f 00000000 12345678 0
D R 1f800020 f 00000000 77778888 0

/* bench/tb_mem_controller.sv */
// memory controller testbench: trace driven cpu data and fetch masters with checked read data
module tb_mem_controller;
   timeunit 1ns;
   timeprecision 100ps;
   import psx_mem_pkg::*;

   localparam int MAIN_WORDS      = 256;
   localparam int RAM_WAIT_CYCLES = 3;
   localparam int MAX_LINES       = 64;
   // every fill word needs a strobe plus RAM_WAIT_CYCLES+1 cycles to its ack
   localparam int FILL_MIN        = MAIN_WORDS * (RAM_WAIT_CYCLES + 1);

   logic  clk, rst;
   logic  dat_cyc, dat_stb, dat_we, dat_ack;
   sel_t  dat_sel;
   addr_t dat_adr;
   word_t dat_wdat, dat_rdat;
   logic  ins_cyc, ins_stb, ins_ack;
   addr_t ins_adr;
   word_t ins_rdat;

   // trace contents with one entry per access
   logic [7:0] t_port [MAX_LINES];         // "D" or "I"
   logic [7:0] t_op   [MAX_LINES];         // "R" or "W"
   addr_t      t_adr  [MAX_LINES];
   sel_t       t_sel  [MAX_LINES];
   word_t      t_wdat [MAX_LINES];
   word_t      t_exp  [MAX_LINES];
   int         t_pair [MAX_LINES];
   int         n_lines = 0;

   int   cycle_cnt   = 0;
   int   cycle_limit = 0;                  // 0 until the trace is loaded
   int   rel_cyc     = 0;                  // cycle of reset release
   int   dat_ack_cyc = 0;
   int   ins_ack_cyc = 0;
   logic ack_seen    = 1'b0;

   mem_controller #(
      .MAIN_WORDS(MAIN_WORDS),
      .RAM_WAIT_CYCLES(RAM_WAIT_CYCLES)
   ) i_dut (
      .clk(clk), .rst(rst),
      .dat_cyc_i(dat_cyc), .dat_stb_i(dat_stb), .dat_we_i(dat_we),
      .dat_sel_i(dat_sel), .dat_adr_i(dat_adr), .dat_dat_i(dat_wdat),
      .dat_dat_o(dat_rdat), .dat_ack_o(dat_ack),
      .ins_cyc_i(ins_cyc), .ins_stb_i(ins_stb), .ins_adr_i(ins_adr),
      .ins_dat_o(ins_rdat), .ins_ack_o(ins_ack)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;              // 20 ns period
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("MISMATCH time %0t: %s got %h expected %h", $time, name, got, exp);
         abort_run("read data check failed");
      end
   endtask

   task automatic check_ack_order(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH time %0t: %s got %b expected %b", $time, name, got, exp);
         abort_run("port priority check failed");
      end
   endtask

   // cycle counter with run limit
   initial begin
      forever begin
         @(posedge clk);
         cycle_cnt++;
         if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("timed out: run still going after %0d cycles", cycle_cnt));
         end
      end
   end

   task automatic load_trace();
      int fd;
      int r;
      logic [7:0] c;
      logic [8*128-1:0] skip_line;
      fd = $fopen("bench/mem_trace.txt", "r");
      if (fd == 0) begin
         abort_run("could not open the trace file bench/mem_trace.txt");
      end
      while (1) begin
         r = $fscanf(fd, " %c", c);        // first column or comment mark
         if (r != 1) break;
         if (c == "#") begin
            r = $fgets(skip_line, fd);     // drop rest of comment
         end else begin
            if (n_lines >= MAX_LINES) abort_run("trace file holds too many lines");
            t_port[n_lines] = c;
            r = $fscanf(fd, " %c %h %h %h %h %d", t_op[n_lines], t_adr[n_lines],
                        t_sel[n_lines], t_wdat[n_lines], t_exp[n_lines], t_pair[n_lines]);
            if (r != 6) abort_run($sformatf("trace entry %0d is malformed", n_lines));
            n_lines++;
         end
      end
      $fclose(fd);
   endtask

   // first port ack must not beat the zero-fill
   task automatic note_ack(output int cyc);
      cyc = cycle_cnt;
      if (!ack_seen) begin
         ack_seen = 1'b1;
         if (cycle_cnt - rel_cyc < FILL_MIN) begin
            abort_run($sformatf("port ack at cycle %0d came before the zero-fill could end",
                                cycle_cnt));
         end
      end
   endtask

   task automatic data_access(input int k);
      @(posedge clk);
      #1;
      dat_cyc  = 1'b1;
      dat_stb  = 1'b1;
      dat_we   = (t_op[k] == "W");
      dat_sel  = t_sel[k];
      dat_adr  = t_adr[k];
      dat_wdat = t_wdat[k];
      @(negedge clk);
      while (!dat_ack) @(negedge clk);     // held until ack
      note_ack(dat_ack_cyc);
      if (t_op[k] != "W") begin
         check_word($sformatf("dat_dat_o (trace entry %0d)", k), dat_rdat, t_exp[k]);
      end
      @(posedge clk);
      #1;
      dat_cyc = 1'b0;                      // drop in cycle after ack
      dat_stb = 1'b0;
      dat_we  = 1'b0;
   endtask

   task automatic fetch_access(input int k);
      @(posedge clk);
      #1;
      ins_cyc = 1'b1;
      ins_stb = 1'b1;
      ins_adr = t_adr[k];
      @(negedge clk);
      while (!ins_ack) @(negedge clk);
      note_ack(ins_ack_cyc);
      check_word($sformatf("ins_dat_o (trace entry %0d)", k), ins_rdat, t_exp[k]);
      @(posedge clk);
      #1;
      ins_cyc = 1'b0;
      ins_stb = 1'b0;
   endtask

   task automatic run_access(input int k);
      if (t_port[k] == "D") data_access(k);
      else fetch_access(k);
   endtask

   // both ports in the same cycle and data expected first
   task automatic run_pair(input int k);
      if (t_port[k] == t_port[k+1]) begin
         abort_run($sformatf("trace pair at entry %0d does not use both ports", k));
      end
      fork
         run_access(k);
         run_access(k + 1);
      join
      check_ack_order("first acking port (1 = fetch)", ins_ack_cyc < dat_ack_cyc, 1'b0);
   endtask

   initial begin
      int k;
      rst      = 1'b1;
      dat_cyc  = 1'b0;
      dat_stb  = 1'b0;
      dat_we   = 1'b0;
      dat_sel  = '0;
      dat_adr  = '0;
      dat_wdat = '0;
      ins_cyc  = 1'b0;
      ins_stb  = 1'b0;
      ins_adr  = '0;
      void'($urandom(32'h27d));
      load_trace();
      cycle_limit = MAIN_WORDS * (RAM_WAIT_CYCLES + 6) + n_lines * (RAM_WAIT_CYCLES + 10) + 100;
      repeat (2) @(posedge clk);
      #1 rst = 1'b0;
      rel_cyc = cycle_cnt;
      k = 0;
      while (k < n_lines) begin
         repeat ($urandom % 4) @(posedge clk); // idle gap 0 to 3
         if (t_pair[k] != 0 && k + 1 < n_lines) begin
            run_pair(k);
            k += 2;
         end else begin
            run_access(k);
            k += 1;
         end
      end
      $display("Finished with no errors");
      $finish;
   end

endmodule

/* filelist.f */
source/psx_mem_pkg.sv
source/mem_arbiter.sv
source/region_router.sv
source/scratchpad_ram.sv
source/main_ram.sv
source/mem_controller.sv
bench/mem_controller_properties.sv
bench/tb_mem_controller.sv

/* run_sim.sh */
#!/bin/sh
# build the memory controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
      --top-module tb_mem_controller -Mdir obj_dir -f filelist.f; then
   echo "verilator build failed"
   exit 1
fi

if ! ./obj_dir/Vtb_mem_controller; then
   echo "simulation reported failure"
   exit 1
fi

echo "simulation passed"
exit 0

/* source/main_ram.sv */
// main ram: mirrored word array with byte-lane writes and a fixed wait-state count
module main_ram #(
   parameter int MAIN_WORDS      = 256,
   parameter int RAM_WAIT_CYCLES = 3
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 stb_i,
   input  logic                 we_i,
   input  psx_mem_pkg::sel_t    sel_i,
   input  psx_mem_pkg::addr_t   adr_i,
   input  psx_mem_pkg::word_t   wdat_i,
   output logic                 ack_o,
   output psx_mem_pkg::word_t   rdat_o
);
   import psx_mem_pkg::*;

   localparam int IDX_W = $clog2(MAIN_WORDS);
   localparam int CNT_W = (RAM_WAIT_CYCLES > 0) ? $clog2(RAM_WAIT_CYCLES + 1) : 1;
   localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(RAM_WAIT_CYCLES);

   word_t             mem [MAIN_WORDS];
   logic [IDX_W-1:0]  idx;
   logic [CNT_W-1:0]  wait_cnt;            // cycles spent on current strobe
   logic              ack_q;
   logic              fire;                // wait over, do the access
   word_t             rdat_q;

   // high address bits dropped, so the array mirrors
   assign idx  = adr_i[IDX_W+1:2];
   assign fire = stb_i && !ack_q && (wait_cnt == WAIT_LAST);

   // latency model standing in for sdram
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wait_cnt <= '0;
         ack_q    <= 1'b0;
      end else if (ack_q) begin
         ack_q <= 1'b0;                    // ack lasts one cycle
      end else if (fire) begin
         ack_q    <= 1'b1;
         wait_cnt <= '0;
      end else if (stb_i) begin
         wait_cnt <= wait_cnt + 1'b1;
      end
   end

   // array contents come from the zero-fill
   always_ff @(posedge clk) begin
      if (fire) begin
         rdat_q <= mem[idx];
         if (we_i) begin
            for (int b = 0; b < 4; b++) begin
               if (sel_i[b]) begin
                  mem[idx][8*b +: 8] <= wdat_i[8*b +: 8];
               end
            end
         end
      end
   end

   assign ack_o  = ack_q;
   assign rdat_o = rdat_q;

endmodule

/* source/mem_arbiter.sv */
// memory arbiter: zero-fills main ram after reset, then serves the data and instruction ports
module mem_arbiter #(
   parameter int MAIN_WORDS = 256
) (
   input  logic                 clk,
   input  logic                 rst,
   // cpu data port
   input  logic                 dat_cyc_i,
   input  logic                 dat_stb_i,
   input  logic                 dat_we_i,
   input  psx_mem_pkg::sel_t    dat_sel_i,
   input  psx_mem_pkg::addr_t   dat_adr_i,
   input  psx_mem_pkg::word_t   dat_dat_i,
   output logic                 dat_ack_o,
   output psx_mem_pkg::word_t   dat_dat_o,
   // cpu instruction port
   input  logic                 ins_cyc_i,
   input  logic                 ins_stb_i,
   input  psx_mem_pkg::addr_t   ins_adr_i,
   output logic                 ins_ack_o,
   output psx_mem_pkg::word_t   ins_dat_o,
   // internal bus towards the router
   output logic                 mem_stb_o,
   output logic                 mem_we_o,
   output psx_mem_pkg::sel_t    mem_sel_o,
   output psx_mem_pkg::addr_t   mem_adr_o,
   output psx_mem_pkg::word_t   mem_wdat_o,
   input  logic                 mem_ack_i,
   input  psx_mem_pkg::word_t   mem_rdat_i
);
   import psx_mem_pkg::*;

   typedef enum logic [2:0] {
      INIT_WRITE,                          // fill word in flight
      INIT_WAIT,                           // region drops ack, step address
      IDLE,
      ACCESS,                              // cpu access in flight
      RESPOND                              // port ack cycle
   } state_t;

   localparam addr_t FILL_LAST = addr_t'((MAIN_WORDS - 1) * 4); // last word of main ram

   state_t state;
   addr_t  fill_adr;                       // zero-fill byte address
   logic   stb_q;
   logic   we_q;
   sel_t   sel_q;
   addr_t  adr_q;
   word_t  wdat_q;
   logic   ins_owner;                      // 1 when the current access is a fetch
   logic   dat_ack_q;
   logic   ins_ack_q;
   word_t  dat_lat;                        // held data port read word
   word_t  ins_lat;                        // held fetch word
   logic   filling;
   logic   dat_req;
   logic   ins_req;

   assign dat_req = dat_cyc_i & dat_stb_i;
   assign ins_req = ins_cyc_i & ins_stb_i;
   assign filling = (state == INIT_WRITE) || (state == INIT_WAIT);

   // control path
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= INIT_WRITE;
         fill_adr  <= '0;
         stb_q     <= 1'b0;
         ins_owner <= 1'b0;
         dat_ack_q <= 1'b0;
         ins_ack_q <= 1'b0;
      end else begin
         case (state)
            INIT_WRITE: begin
               if (!stb_q) begin
                  stb_q <= 1'b1;           // launch fill write
               end else if (mem_ack_i) begin
                  stb_q <= 1'b0;
                  state <= INIT_WAIT;
               end
            end
            INIT_WAIT: begin
               if (fill_adr == FILL_LAST) begin
                  state <= IDLE;           // fill done, open the ports
               end else begin
                  fill_adr <= fill_adr + addr_t'(4);
                  state    <= INIT_WRITE;
               end
            end
            IDLE: begin
               if (dat_req) begin          // data wins a tie
                  ins_owner <= 1'b0;
                  stb_q     <= 1'b1;
                  state     <= ACCESS;
               end else if (ins_req) begin
                  ins_owner <= 1'b1;
                  stb_q     <= 1'b1;
                  state     <= ACCESS;
               end
            end
            ACCESS: begin
               if (mem_ack_i) begin
                  stb_q     <= 1'b0;
                  dat_ack_q <= !ins_owner; // port ack lands next cycle
                  ins_ack_q <= ins_owner;
                  state     <= RESPOND;
               end
            end
            RESPOND: begin
               dat_ack_q <= 1'b0;          // single cycle pulse
               ins_ack_q <= 1'b0;
               state     <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // request fields and read latches
   always_ff @(posedge clk) begin
      if (state == INIT_WRITE && !stb_q) begin
         adr_q  <= fill_adr;
         we_q   <= 1'b1;
         wdat_q <= '0;                     // clear value
      end else if (state == IDLE && dat_req) begin
         adr_q  <= dat_adr_i;
         we_q   <= dat_we_i;
         sel_q  <= dat_sel_i;
         wdat_q <= dat_dat_i;
      end else if (state == IDLE && ins_req) begin
         adr_q  <= ins_adr_i;
         we_q   <= 1'b0;                   // fetch is read only
         sel_q  <= '1;
      end
      if (state == ACCESS && mem_ack_i && !we_q) begin
         if (ins_owner) begin
            ins_lat <= mem_rdat_i;
         end else begin
            dat_lat <= mem_rdat_i;
         end
      end
   end

   assign mem_stb_o  = stb_q;
   assign mem_we_o   = we_q;
   assign mem_sel_o  = filling ? '1 : sel_q; // full words during fill
   assign mem_adr_o  = adr_q;
   assign mem_wdat_o = wdat_q;

   assign dat_ack_o  = dat_ack_q;
   assign ins_ack_o  = ins_ack_q;
   assign dat_dat_o  = dat_lat;
   assign ins_dat_o  = ins_lat;

endmodule

/* source/mem_controller.sv */
// memory controller top: arbiter, region router, scratchpad and main ram behind two cpu ports
module mem_controller #(
   parameter int MAIN_WORDS      = 256,
   parameter int RAM_WAIT_CYCLES = 3
) (
   input  logic                 clk,
   input  logic                 rst,
   // cpu data port
   input  logic                 dat_cyc_i,
   input  logic                 dat_stb_i,
   input  logic                 dat_we_i,
   input  psx_mem_pkg::sel_t    dat_sel_i,
   input  psx_mem_pkg::addr_t   dat_adr_i,
   input  psx_mem_pkg::word_t   dat_dat_i,
   output psx_mem_pkg::word_t   dat_dat_o,
   output logic                 dat_ack_o,
   // cpu instruction port
   input  logic                 ins_cyc_i,
   input  logic                 ins_stb_i,
   input  psx_mem_pkg::addr_t   ins_adr_i,
   output psx_mem_pkg::word_t   ins_dat_o,
   output logic                 ins_ack_o
);
   import psx_mem_pkg::*;

   // internal bus
   logic  mem_stb, mem_we, mem_ack;
   sel_t  mem_sel;
   addr_t mem_adr;
   word_t mem_wdat, mem_rdat;
   // per region returns
   logic  scp_stb, scp_ack, ram_stb, ram_ack;
   word_t scp_rdat, ram_rdat;

   mem_arbiter #(.MAIN_WORDS(MAIN_WORDS)) i_arbiter (
      .clk(clk), .rst(rst),
      .dat_cyc_i(dat_cyc_i), .dat_stb_i(dat_stb_i), .dat_we_i(dat_we_i),
      .dat_sel_i(dat_sel_i), .dat_adr_i(dat_adr_i), .dat_dat_i(dat_dat_i),
      .dat_ack_o(dat_ack_o), .dat_dat_o(dat_dat_o),
      .ins_cyc_i(ins_cyc_i), .ins_stb_i(ins_stb_i), .ins_adr_i(ins_adr_i),
      .ins_ack_o(ins_ack_o), .ins_dat_o(ins_dat_o),
      .mem_stb_o(mem_stb), .mem_we_o(mem_we), .mem_sel_o(mem_sel),
      .mem_adr_o(mem_adr), .mem_wdat_o(mem_wdat),
      .mem_ack_i(mem_ack), .mem_rdat_i(mem_rdat)
   );

   region_router i_router (
      .clk(clk), .rst(rst),
      .mem_stb_i(mem_stb), .mem_adr_i(mem_adr),
      .mem_ack_o(mem_ack), .mem_rdat_o(mem_rdat),
      .scp_stb_o(scp_stb), .scp_ack_i(scp_ack), .scp_rdat_i(scp_rdat),
      .ram_stb_o(ram_stb), .ram_ack_i(ram_ack), .ram_rdat_i(ram_rdat)
   );

   scratchpad_ram i_scpad (
      .clk(clk), .rst(rst),
      .stb_i(scp_stb), .we_i(mem_we), .sel_i(mem_sel),
      .adr_i(mem_adr), .wdat_i(mem_wdat),
      .ack_o(scp_ack), .rdat_o(scp_rdat)
   );

   main_ram #(
      .MAIN_WORDS(MAIN_WORDS),
      .RAM_WAIT_CYCLES(RAM_WAIT_CYCLES)
   ) i_main_ram (
      .clk(clk), .rst(rst),
      .stb_i(ram_stb), .we_i(mem_we), .sel_i(mem_sel),
      .adr_i(mem_adr), .wdat_i(mem_wdat),
      .ack_o(ram_ack), .rdat_o(ram_rdat)
   );

endmodule

/* source/psx_mem_pkg.sv */
// psx memory package: shared word, address and lane types plus scratchpad window constants
package psx_mem_pkg;

   // bus payload types
   typedef logic [31:0] word_t;            // one data word
   typedef logic [31:0] addr_t;            // byte address
   typedef logic [3:0]  sel_t;             // byte lanes, bit 0 is the low byte

   // scratchpad window
   localparam addr_t SCPAD_BASE  = 32'h1F80_0000; // start of the 1 KiB window
   localparam int    SCPAD_WORDS = 256;           // depth in words

   // region picked by the router
   typedef enum logic {
      REGION_MAIN  = 1'b0,                 // main ram, mirrored
      REGION_SCPAD = 1'b1                  // on-chip scratchpad
   } region_e;

endpackage

/* source/region_router.sv */
// region router: decodes the bus address and steers strobe, ack and read data per region
module region_router (
   input  logic                 clk,
   input  logic                 rst,
   // internal bus from the arbiter
   input  logic                 mem_stb_i,
   input  psx_mem_pkg::addr_t   mem_adr_i,
   output logic                 mem_ack_o,
   output psx_mem_pkg::word_t   mem_rdat_o,
   // scratchpad side
   output logic                 scp_stb_o,
   input  logic                 scp_ack_i,
   input  psx_mem_pkg::word_t   scp_rdat_i,
   // main ram side
   output logic                 ram_stb_o,
   input  logic                 ram_ack_i,
   input  psx_mem_pkg::word_t   ram_rdat_i
);
   import psx_mem_pkg::*;

   localparam addr_t SCPAD_END = SCPAD_BASE + addr_t'(SCPAD_WORDS * 4); // first byte past window

   logic    hit_scpad;
   region_e cur_region;                    // live decode
   region_e region_q;                      // region of the access in flight
   logic    stb_d;                         // strobe one cycle back

   // window compare
   assign hit_scpad  = (mem_adr_i >= SCPAD_BASE) && (mem_adr_i < SCPAD_END);
   assign cur_region = hit_scpad ? REGION_SCPAD : REGION_MAIN;

   // strobe goes to one region only
   assign scp_stb_o = mem_stb_i && (cur_region == REGION_SCPAD);
   assign ram_stb_o = mem_stb_i && (cur_region == REGION_MAIN);

   // capture region at strobe start
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         stb_d    <= 1'b0;
         region_q <= REGION_MAIN;
      end else begin
         stb_d <= mem_stb_i;
         if (mem_stb_i && !stb_d) begin
            region_q <= cur_region;
         end
      end
   end

   // return path follows the captured region
   always_comb begin
      if (region_q == REGION_SCPAD) begin
         mem_ack_o  = scp_ack_i;
         mem_rdat_o = scp_rdat_i;
      end else begin
         mem_ack_o  = ram_ack_i;
         mem_rdat_o = ram_rdat_i;
      end
   end

endmodule

/* source/scratchpad_ram.sv */
// scratchpad ram: 1 KiB on-chip word store with byte-lane writes and one wait state
module scratchpad_ram (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 stb_i,
   input  logic                 we_i,
   input  psx_mem_pkg::sel_t    sel_i,
   input  psx_mem_pkg::addr_t   adr_i,
   input  psx_mem_pkg::word_t   wdat_i,
   output logic                 ack_o,
   output psx_mem_pkg::word_t   rdat_o
);
   import psx_mem_pkg::*;

   localparam int IDX_W = $clog2(SCPAD_WORDS);

   word_t             mem [SCPAD_WORDS];
   logic [IDX_W-1:0]  idx;                 // word inside the window
   logic              ack_q;
   logic              fire;                // access accepted this cycle
   word_t             rdat_q;

   assign idx  = adr_i[IDX_W+1:2];         // window is size aligned
   assign fire = stb_i && !ack_q;          // stb during ack is ignored

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= fire;                    // ack one cycle after strobe
      end
   end

   // array and read register
   always_ff @(posedge clk) begin
      if (fire) begin
         rdat_q <= mem[idx];
         if (we_i) begin
            for (int b = 0; b < 4; b++) begin
               if (sel_i[b]) begin
                  mem[idx][8*b +: 8] <= wdat_i[8*b +: 8]; // selected lanes only
               end
            end
         end
      end
   end

   assign ack_o  = ack_q;
   assign rdat_o = rdat_q;

endmodule
